//--- bench/ctrlTopTb.sv
`include "mips_cfg.svh"

module ctrlTopTb import isaPkg::*, ctrlPkg::*; ();

    localparam int irTimeout = 40; // longest instruction takes 12 cycles

    logic                 clk;
    logic                 reset;
    logic [`OPCODE_W-1:0] opcode;
    logic [`FUNCT_W-1:0]  funct;
    logic                 overflow;
    logic                 equal;
    logic                 greater;

    logic      memWrite;
    logic      pcWrite;
    logic      irWrite;
    logic      regWrite;
    logic      abWrite;
    logic      aluOutWrite;
    logic      epcWrite;
    aluOp_t    aluControl;
    regDst_t   regDstSelect;
    memToReg_t memToRegSelect;
    pcSource_t pcSourceSelect;
    aluSrcA_t  aluSrcASelect;
    aluSrcB_t  aluSrcBSelect;
    iOrD_t     iOrDSelect;

    integer seed;
    int     cycle;        // 0 is the irWrite cycle of the running instruction
    int     firstIrCycle; // cycle of the next irWrite, 0 until seen
    int     pcWrites;
    int     regWrites;
    int     memWrites;
    int     epcWrites;
    int     errorCount;
    int     checkTotal;

    ctrlTop u_ctrlTop (
        .clk            (clk),
        .reset          (reset),
        .opcode         (opcode),
        .funct          (funct),
        .overflow       (overflow),
        .equal          (equal),
        .greater        (greater),
        .memWrite       (memWrite),
        .pcWrite        (pcWrite),
        .irWrite        (irWrite),
        .regWrite       (regWrite),
        .abWrite        (abWrite),
        .aluOutWrite    (aluOutWrite),
        .epcWrite       (epcWrite),
        .aluControl     (aluControl),
        .regDstSelect   (regDstSelect),
        .memToRegSelect (memToRegSelect),
        .pcSourceSelect (pcSourceSelect),
        .aluSrcASelect  (aluSrcASelect),
        .aluSrcBSelect  (aluSrcBSelect),
        .iOrDSelect     (iOrDSelect)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic compareBits(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checkTotal++;
        if (expected !== actual) begin
            errorCount++;
            $display("[FAIL] %s expected %0h got %0h at cycle %0d", name, expected, actual, cycle);
        end
    endtask

    task automatic checkStrobe(input string name, input logic expected, input logic actual);
        compareBits(name, 32'(expected), 32'(actual));
    endtask

    task automatic checkAluOp(input string name, input aluOp_t expected, input aluOp_t actual);
        compareBits(name, 32'(expected), 32'(actual));
    endtask

    task automatic checkRegDst(input string name, input regDst_t expected,
                               input regDst_t actual);
        compareBits(name, 32'(expected), 32'(actual));
    endtask

    task automatic checkMemToReg(input string name, input memToReg_t expected,
                                 input memToReg_t actual);
        compareBits(name, 32'(expected), 32'(actual));
    endtask

    task automatic checkPcSource(input string name, input pcSource_t expected,
                                 input pcSource_t actual);
        compareBits(name, 32'(expected), 32'(actual));
    endtask

    task automatic checkAluSrcA(input string name, input aluSrcA_t expected,
                                input aluSrcA_t actual);
        compareBits(name, 32'(expected), 32'(actual));
    endtask

    task automatic checkAluSrcB(input string name, input aluSrcB_t expected,
                                input aluSrcB_t actual);
        compareBits(name, 32'(expected), 32'(actual));
    endtask

    task automatic checkIOrD(input string name, input iOrD_t expected, input iOrD_t actual);
        compareBits(name, 32'(expected), 32'(actual));
    endtask

    task automatic checkCount(input string name, input int expected, input int actual);
        compareBits(name, expected, actual);
    endtask

    // one falling edge, strobes tallied per instruction
    task automatic advance();
        @(negedge clk);
        cycle++;
        if (pcWrite) pcWrites++;
        if (regWrite) regWrites++;
        if (memWrite) memWrites++;
        if (epcWrite) epcWrites++;
        if (irWrite && firstIrCycle == 0) firstIrCycle = cycle;
    endtask

    task automatic gotoCycle(input int target);
        while (cycle < target) advance();
    endtask

    task automatic waitIrWrite();
        int guard;
        guard = 0;
        while (firstIrCycle == 0 && guard < irTimeout) begin
            advance();
            guard++;
        end
        if (firstIrCycle == 0) begin
            errorCount++;
            $display("timeout: irWrite did not come within %0d cycles", irTimeout);
        end
    endtask

    task automatic checkIdle();
        checkStrobe("memWrite", 1'b0, memWrite);
        checkStrobe("pcWrite", 1'b0, pcWrite);
        checkStrobe("irWrite", 1'b0, irWrite);
        checkStrobe("regWrite", 1'b0, regWrite);
        checkStrobe("abWrite", 1'b0, abWrite);
        checkStrobe("aluOutWrite", 1'b0, aluOutWrite);
        checkStrobe("epcWrite", 1'b0, epcWrite);
        checkAluOp("aluControl", ALU_PASS, aluControl);
        checkRegDst("regDstSelect", DST_RT, regDstSelect);
        checkMemToReg("memToRegSelect", WB_ALU_OUT, memToRegSelect);
        checkPcSource("pcSourceSelect", PC_MEM_DATA, pcSourceSelect);
        checkAluSrcA("aluSrcASelect", SRCA_PC, aluSrcASelect);
        checkAluSrcB("aluSrcBSelect", SRCB_REG_B, aluSrcBSelect);
        checkIOrD("iOrDSelect", ADDR_PC, iOrDSelect);
    endtask

    // branch target in cycle 1, register read in cycle 2
    task automatic checkDecode();
        gotoCycle(1);
        checkStrobe("aluOutWrite", 1'b1, aluOutWrite);
        checkAluSrcA("aluSrcASelect", SRCA_PC, aluSrcASelect);
        checkAluSrcB("aluSrcBSelect", SRCB_BRANCH_OFFSET, aluSrcBSelect);
        checkAluOp("aluControl", ALU_ADD, aluControl);
        gotoCycle(2);
        checkStrobe("abWrite", 1'b1, abWrite);
    endtask

    // called on the falling edge of an irWrite cycle
    task automatic startInstr(input logic [`OPCODE_W-1:0] op, input logic [`FUNCT_W-1:0] fn,
                              input logic ovf, input logic eq, input logic gt);
        opcode       = op;
        funct        = fn;
        overflow     = ovf;
        equal        = eq;
        greater      = gt;
        cycle        = 0;
        firstIrCycle = 0;
        pcWrites     = 0;
        regWrites    = 0;
        memWrites    = 0;
        epcWrites    = 0;
    endtask

    // pcWrite tally includes the pc + 4 of the next fetch
    task automatic finishInstr(input int expIr, input int expPc, input int expReg,
                               input int expMem, input int expEpc);
        waitIrWrite();
        checkCount("next irWrite cycle", expIr, firstIrCycle);
        checkCount("pcWrite pulses", expPc, pcWrites);
        checkCount("regWrite pulses", expReg, regWrites);
        checkCount("memWrite pulses", expMem, memWrites);
        checkCount("epcWrite pulses", expEpc, epcWrites);
    endtask

    function automatic logic [`OPCODE_W-1:0] pickBranchOp(input logic [1:0] idx);
        case (idx)
            2'd0:    return BEQ;
            2'd1:    return BNE;
            2'd2:    return BLE;
            default: return BGT;
        endcase
    endfunction

    function automatic logic branchTaken(input logic [`OPCODE_W-1:0] op, input logic eq,
                                         input logic gt);
        case (op)
            BEQ:     return eq;
            BNE:     return !eq;
            BLE:     return !gt;
            default: return gt;
        endcase
    endfunction

    task automatic testReset();
        int i;
        for (i = 0; i < 8; i++) begin
            @(negedge clk);
            checkIdle();
        end
        reset        = 1'b0;
        cycle        = 1; // still FETCH_ADDR
        firstIrCycle = 0;
        gotoCycle(2);
        checkStrobe("irWrite", 1'b0, irWrite);
        checkStrobe("pcWrite", 1'b1, pcWrite);
        checkPcSource("pcSourceSelect", PC_ALU_RESULT, pcSourceSelect);
        checkAluSrcB("aluSrcBSelect", SRCB_FOUR, aluSrcBSelect);
        waitIrWrite();
        checkCount("first irWrite cycle", 3, firstIrCycle);
    endtask

    task automatic runAluCase(input logic [`OPCODE_W-1:0] op, input logic [`FUNCT_W-1:0] fn,
                              input logic ovf, input aluOp_t expAlu, input regDst_t expDst,
                              input memToReg_t expWb);
        aluSrcB_t expSrcB;
        if (op == R_FORMAT) begin
            expSrcB = SRCB_REG_B;
        end else begin
            expSrcB = SRCB_IMM;
        end
        startInstr(op, fn, ovf, 1'b0, 1'b0);
        checkDecode();
        gotoCycle(3);
        checkAluOp("aluControl", expAlu, aluControl);
        checkStrobe("aluOutWrite", 1'b1, aluOutWrite);
        checkAluSrcA("aluSrcASelect", SRCA_REG_A, aluSrcASelect);
        checkAluSrcB("aluSrcBSelect", expSrcB, aluSrcBSelect);
        gotoCycle(4);
        checkStrobe("regWrite", 1'b1, regWrite);
        checkRegDst("regDstSelect", expDst, regDstSelect);
        checkMemToReg("memToRegSelect", expWb, memToRegSelect);
        finishInstr(8, 1, 1, 0, 0);
    endtask

    task automatic runOverflowCase(input logic [`OPCODE_W-1:0] op,
                                   input logic [`FUNCT_W-1:0] fn);
        startInstr(op, fn, 1'b1, 1'b0, 1'b0);
        gotoCycle(4);
        checkStrobe("epcWrite", 1'b1, epcWrite);
        checkStrobe("regWrite", 1'b0, regWrite);
        gotoCycle(5);
        checkIOrD("iOrDSelect", ADDR_OVERFLOW_VEC, iOrDSelect);
        gotoCycle(6 + `MEM_WAIT_CYCLES);
        checkStrobe("pcWrite", 1'b1, pcWrite);
        checkPcSource("pcSourceSelect", PC_MEM_DATA, pcSourceSelect);
        finishInstr(10 + `MEM_WAIT_CYCLES, 2, 0, 0, 1);
    endtask

    task automatic testAluOps();
        runAluCase(R_FORMAT, ADD, 1'b0, ALU_ADD, DST_RD, WB_ALU_OUT);
        runAluCase(R_FORMAT, SUB, 1'b0, ALU_SUB, DST_RD, WB_ALU_OUT);
        runAluCase(R_FORMAT, AND, 1'b0, ALU_AND, DST_RD, WB_ALU_OUT);
        runAluCase(R_FORMAT, SLT, 1'b0, ALU_CMP, DST_RD, WB_LESS_THAN);
        runAluCase(ADDI, '0, 1'b0, ALU_ADD, DST_RT, WB_ALU_OUT);
        runAluCase(ADDIU, '0, 1'b0, ALU_ADD, DST_RT, WB_ALU_OUT);
        runAluCase(SLTI, '0, 1'b0, ALU_CMP, DST_RT, WB_LESS_THAN);
        runAluCase(LUI, '0, 1'b0, ALU_ADD, DST_RT, WB_UPPER_IMM);
        runOverflowCase(R_FORMAT, ADD);
        runOverflowCase(R_FORMAT, SUB);
        runOverflowCase(ADDI, '0);
        runAluCase(ADDIU, '0, 1'b1, ALU_ADD, DST_RT, WB_ALU_OUT); // unsigned, never traps
    endtask

    task automatic testMemory();
        int c;
        startInstr(LW, '0, 1'b0, 1'b0, 1'b0);
        gotoCycle(3);
        checkStrobe("aluOutWrite", 1'b1, aluOutWrite);
        checkAluOp("aluControl", ALU_ADD, aluControl);
        checkAluSrcA("aluSrcASelect", SRCA_REG_A, aluSrcASelect);
        checkAluSrcB("aluSrcBSelect", SRCB_IMM, aluSrcBSelect);
        for (c = 4; c < 4 + `MEM_WAIT_CYCLES; c++) begin
            gotoCycle(c);
            checkIOrD("iOrDSelect", ADDR_ALU_OUT, iOrDSelect);
        end
        gotoCycle(4 + `MEM_WAIT_CYCLES);
        checkStrobe("regWrite", 1'b1, regWrite);
        checkMemToReg("memToRegSelect", WB_MEM_DATA, memToRegSelect);
        checkRegDst("regDstSelect", DST_RT, regDstSelect);
        finishInstr(8 + `MEM_WAIT_CYCLES, 1, 1, 0, 0);

        startInstr(SW, '0, 1'b0, 1'b0, 1'b0);
        for (c = 4; c < 4 + `MEM_WAIT_CYCLES; c++) begin
            gotoCycle(c);
            checkIOrD("iOrDSelect", ADDR_ALU_OUT, iOrDSelect);
        end
        gotoCycle(4 + `MEM_WAIT_CYCLES);
        checkStrobe("memWrite", 1'b1, memWrite);
        checkStrobe("regWrite", 1'b0, regWrite);
        finishInstr(8 + `MEM_WAIT_CYCLES, 1, 0, 1, 0);
    endtask

    task automatic testBranches();
        int                   n;
        integer               r;
        logic [`OPCODE_W-1:0] op;
        logic                 eq;
        logic                 gt;
        logic                 taken;
        for (n = 0; n < 20; n++) begin
            r     = $random(seed);
            op    = pickBranchOp(r[1:0]);
            eq    = r[2];
            gt    = r[3] & ~r[2]; // greater and equal never together
            taken = branchTaken(op, eq, gt);
            startInstr(op, '0, 1'b0, eq, gt);
            gotoCycle(3);
            checkAluOp("aluControl", ALU_CMP, aluControl);
            checkAluSrcA("aluSrcASelect", SRCA_REG_A, aluSrcASelect);
            checkAluSrcB("aluSrcBSelect", SRCB_REG_B, aluSrcBSelect);
            gotoCycle(4);
            checkStrobe("pcWrite", taken, pcWrite);
            if (taken) begin
                checkPcSource("pcSourceSelect", PC_ALU_OUT, pcSourceSelect);
                finishInstr(8, 2, 0, 0, 0);
            end else begin
                finishInstr(7, 1, 0, 0, 0);
            end
        end
    endtask

    task automatic testJumps();
        startInstr(J, '0, 1'b0, 1'b0, 1'b0);
        gotoCycle(3);
        checkStrobe("pcWrite", 1'b1, pcWrite);
        checkPcSource("pcSourceSelect", PC_JUMP_TARGET, pcSourceSelect);
        finishInstr(7, 2, 0, 0, 0);

        startInstr(JAL, '0, 1'b0, 1'b0, 1'b0);
        gotoCycle(3);
        checkStrobe("aluOutWrite", 1'b1, aluOutWrite);
        gotoCycle(4);
        checkStrobe("regWrite", 1'b1, regWrite);
        checkRegDst("regDstSelect", DST_LINK, regDstSelect);
        checkMemToReg("memToRegSelect", WB_ALU_OUT, memToRegSelect);
        gotoCycle(5);
        checkStrobe("pcWrite", 1'b1, pcWrite);
        checkPcSource("pcSourceSelect", PC_JUMP_TARGET, pcSourceSelect);
        finishInstr(9, 2, 1, 0, 0);
    endtask

    task automatic runIllegalCase(input logic [`OPCODE_W-1:0] op,
                                  input logic [`FUNCT_W-1:0] fn);
        startInstr(op, fn, 1'b0, 1'b0, 1'b0);
        gotoCycle(3);
        checkStrobe("epcWrite", 1'b1, epcWrite);
        checkAluOp("aluControl", ALU_SUB, aluControl);
        checkAluSrcA("aluSrcASelect", SRCA_PC, aluSrcASelect);
        checkAluSrcB("aluSrcBSelect", SRCB_FOUR, aluSrcBSelect);
        gotoCycle(4);
        checkIOrD("iOrDSelect", ADDR_OPCODE_VEC, iOrDSelect);
        gotoCycle(5 + `MEM_WAIT_CYCLES);
        checkStrobe("pcWrite", 1'b1, pcWrite);
        checkPcSource("pcSourceSelect", PC_MEM_DATA, pcSourceSelect);
        finishInstr(9 + `MEM_WAIT_CYCLES, 2, 0, 0, 1);
    endtask

    task automatic testIllegal();
        runIllegalCase(6'h3f, '0);       // no such opcode
        runIllegalCase(R_FORMAT, 6'h3f); // no such funct
    endtask

    initial begin
        seed         = 42684;
        reset        = 1'b1;
        opcode       = '0;
        funct        = '0;
        overflow     = 1'b0;
        equal        = 1'b0;
        greater      = 1'b0;
        cycle        = 0;
        firstIrCycle = 0;
        pcWrites     = 0;
        regWrites    = 0;
        memWrites    = 0;
        epcWrites    = 0;
        errorCount   = 0;
        checkTotal   = 0;

        testReset();
        testAluOps();
        testMemory();
        testBranches();
        testJumps();
        testIllegal();

        $display("checks: %0d errors: %0d", checkTotal, errorCount);
        if (errorCount == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

//--- build.f
+incdir+hw
hw/isaPkg.sv
hw/ctrlPkg.sv
hw/decodeIf.sv
hw/instrDecoder.sv
hw/waitTimer.sv
hw/mainSequencer.sv
hw/controlEncoder.sv
hw/ctrlTop.sv
bench/ctrlTopTb.sv

//--- hw/controlEncoder.sv
module controlEncoder import ctrlPkg::*; (
    input  ctrlState_t state,
    decodeIf.encoder   dec,
    output logic       memWrite,
    output logic       pcWrite,
    output logic       irWrite,
    output logic       regWrite,
    output logic       abWrite,
    output logic       aluOutWrite,
    output logic       epcWrite,
    output aluOp_t     aluControl,
    output regDst_t    regDstSelect,
    output memToReg_t  memToRegSelect,
    output pcSource_t  pcSourceSelect,
    output aluSrcA_t   aluSrcASelect,
    output aluSrcB_t   aluSrcBSelect,
    output iOrD_t      iOrDSelect
);

    always_comb begin
        memWrite       = 1'b0;
        pcWrite        = 1'b0;
        irWrite        = 1'b0;
        regWrite       = 1'b0;
        abWrite        = 1'b0;
        aluOutWrite    = 1'b0;
        epcWrite       = 1'b0;
        aluControl     = ALU_PASS;
        regDstSelect   = DST_RT;
        memToRegSelect = WB_ALU_OUT;
        pcSourceSelect = PC_MEM_DATA;
        aluSrcASelect  = SRCA_PC;
        aluSrcBSelect  = SRCB_REG_B;
        iOrDSelect     = ADDR_PC;

        case (state)
            FETCH_PC: begin // pc + 4
                aluSrcBSelect  = SRCB_FOUR;
                aluControl     = ALU_ADD;
                pcSourceSelect = PC_ALU_RESULT;
                pcWrite        = 1'b1;
            end
            FETCH_IR: irWrite = 1'b1;
            DECODE_TARGET: begin
                // branch target computed ahead of the class decision
                aluSrcBSelect = SRCB_BRANCH_OFFSET;
                aluControl    = ALU_ADD;
                aluOutWrite   = 1'b1;
            end
            DECODE_REGS: abWrite = 1'b1;

            EXEC_ALU_R: begin
                aluSrcASelect = SRCA_REG_A;
                aluControl    = dec.aluOp;
                aluOutWrite   = 1'b1;
            end
            EXEC_ALU_I: begin
                aluSrcASelect = SRCA_REG_A;
                aluSrcBSelect = SRCB_IMM;
                aluControl    = dec.aluOp;
                aluOutWrite   = 1'b1;
            end
            ALU_WB: begin
                regWrite       = 1'b1;
                regDstSelect   = dec.wbDest;
                memToRegSelect = dec.wbSource;
            end

            EXEC_MEM: begin // effective address
                aluSrcASelect = SRCA_REG_A;
                aluSrcBSelect = SRCB_IMM;
                aluControl    = ALU_ADD;
                aluOutWrite   = 1'b1;
            end
            MEM_WAIT: iOrDSelect = ADDR_ALU_OUT;
            LOAD_WB: begin
                iOrDSelect     = ADDR_ALU_OUT;
                regWrite       = 1'b1;
                memToRegSelect = WB_MEM_DATA;
            end
            STORE_WRITE: begin
                iOrDSelect = ADDR_ALU_OUT;
                memWrite   = 1'b1;
            end

            EXEC_BRANCH: begin // flags only, nothing written
                aluSrcASelect = SRCA_REG_A;
                aluControl    = ALU_CMP;
            end
            BRANCH_TAKE: begin
                pcWrite        = 1'b1;
                pcSourceSelect = PC_ALU_OUT;
            end

            JUMP: begin
                pcWrite        = 1'b1;
                pcSourceSelect = PC_JUMP_TARGET;
            end
            EXEC_JAL: aluOutWrite = 1'b1; // return address, pc passes through
            JAL_LINK: begin
                regWrite     = 1'b1;
                regDstSelect = DST_LINK;
            end

            OPC_EPC,
            OVF_EPC: begin // epc gets pc - 4
                aluSrcBSelect = SRCB_FOUR;
                aluControl    = ALU_SUB;
                epcWrite      = 1'b1;
            end
            OPC_VECTOR: iOrDSelect = ADDR_OPCODE_VEC;
            OVF_VECTOR: iOrDSelect = ADDR_OVERFLOW_VEC;
            EXC_LOAD: pcWrite = 1'b1; // handler address from memory

            default: ;
        endcase
    end

endmodule

//--- hw/ctrlPkg.sv
package ctrlPkg;

    typedef enum logic [4:0] {
        FETCH_ADDR    = 5'd0,
        FETCH_PC      = 5'd1,
        FETCH_IR      = 5'd2,
        DECODE_TARGET = 5'd3,
        DECODE_REGS   = 5'd4,
        EXEC_ALU_R    = 5'd5,
        EXEC_ALU_I    = 5'd6,
        ALU_WB        = 5'd7,
        EXEC_MEM      = 5'd8,
        MEM_WAIT      = 5'd9,
        LOAD_WB       = 5'd10,
        STORE_WRITE   = 5'd11,
        EXEC_BRANCH   = 5'd12,
        BRANCH_TAKE   = 5'd13,
        JUMP          = 5'd14,
        EXEC_JAL      = 5'd15,
        JAL_LINK      = 5'd16,
        OPC_EPC       = 5'd17,
        OPC_VECTOR    = 5'd18,
        OVF_EPC       = 5'd19,
        OVF_VECTOR    = 5'd20,
        EXC_WAIT      = 5'd21,
        EXC_LOAD      = 5'd22,
        FINISH        = 5'd23
    } ctrlState_t;

    typedef enum logic [2:0] {
        ALU_PASS = 3'd0, // operand A unchanged
        ALU_ADD  = 3'd1,
        ALU_SUB  = 3'd2,
        ALU_AND  = 3'd3,
        ALU_CMP  = 3'd7
    } aluOp_t;

    typedef enum logic [1:0] {DST_RT = 2'd0, DST_RD = 2'd1, DST_LINK = 2'd3} regDst_t;

    typedef enum logic [1:0] {
        WB_ALU_OUT, WB_MEM_DATA, WB_LESS_THAN, WB_UPPER_IMM
    } memToReg_t;

    // exception vector read back from memory on code 0
    typedef enum logic [1:0] {
        PC_MEM_DATA, PC_ALU_RESULT, PC_ALU_OUT, PC_JUMP_TARGET
    } pcSource_t;

    typedef enum logic {SRCA_PC, SRCA_REG_A} aluSrcA_t;

    typedef enum logic [1:0] {
        SRCB_REG_B, SRCB_FOUR, SRCB_IMM, SRCB_BRANCH_OFFSET
    } aluSrcB_t;

    typedef enum logic [1:0] {
        ADDR_PC, ADDR_ALU_OUT, ADDR_OPCODE_VEC, ADDR_OVERFLOW_VEC
    } iOrD_t;

endpackage

//--- hw/ctrlTop.sv
`include "mips_cfg.svh"

module ctrlTop import isaPkg::*, ctrlPkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    input  logic [`OPCODE_W-1:0] opcode,
    input  logic [`FUNCT_W-1:0]  funct,
    input  logic                 overflow,
    input  logic                 equal,
    input  logic                 greater,
    output logic                 memWrite,
    output logic                 pcWrite,
    output logic                 irWrite,
    output logic                 regWrite,
    output logic                 abWrite,
    output logic                 aluOutWrite,
    output logic                 epcWrite,
    output aluOp_t               aluControl,
    output regDst_t              regDstSelect,
    output memToReg_t            memToRegSelect,
    output pcSource_t            pcSourceSelect,
    output aluSrcA_t             aluSrcASelect,
    output aluSrcB_t             aluSrcBSelect,
    output iOrD_t                iOrDSelect
);

    ctrlState_t state;
    logic       timerStart;
    logic       timerDone;

    decodeIf u_decodeIf ();

    // raw fields, unknown codes stay visible to the decoder
    instrDecoder u_instrDecoder (
        .opcode (opcode_t'(opcode)),
        .funct  (funct_t'(funct)),
        .dec    (u_decodeIf.decoder)
    );

    waitTimer u_waitTimer (
        .clk   (clk),
        .reset (reset),
        .start (timerStart),
        .done  (timerDone)
    );

    mainSequencer u_mainSequencer (
        .clk        (clk),
        .reset      (reset),
        .dec        (u_decodeIf.sequencer),
        .overflow   (overflow),
        .equal      (equal),
        .greater    (greater),
        .timerDone  (timerDone),
        .timerStart (timerStart),
        .state      (state)
    );

    controlEncoder u_controlEncoder (
        .state          (state),
        .dec            (u_decodeIf.encoder),
        .memWrite       (memWrite),
        .pcWrite        (pcWrite),
        .irWrite        (irWrite),
        .regWrite       (regWrite),
        .abWrite        (abWrite),
        .aluOutWrite    (aluOutWrite),
        .epcWrite       (epcWrite),
        .aluControl     (aluControl),
        .regDstSelect   (regDstSelect),
        .memToRegSelect (memToRegSelect),
        .pcSourceSelect (pcSourceSelect),
        .aluSrcASelect  (aluSrcASelect),
        .aluSrcBSelect  (aluSrcBSelect),
        .iOrDSelect     (iOrDSelect)
    );

endmodule

//--- hw/decodeIf.sv
interface decodeIf import isaPkg::*, ctrlPkg::*; ();

    instrClass_t instrClass;
    branchCond_t branchCond;
    logic        trapsOverflow;
    aluOp_t      aluOp;
    memToReg_t   wbSource;
    regDst_t     wbDest;

    modport decoder (
        output instrClass, branchCond, trapsOverflow, aluOp, wbSource, wbDest
    );

    modport sequencer (input instrClass, branchCond, trapsOverflow);

    modport encoder (input aluOp, wbSource, wbDest);

endinterface

//--- hw/instrDecoder.sv
module instrDecoder import isaPkg::*, ctrlPkg::*; (
    input opcode_t opcode,
    input funct_t  funct,
    decodeIf.decoder dec
);

    always_comb begin
        dec.instrClass    = CLS_ILLEGAL;
        dec.branchCond    = BR_EQ;
        dec.trapsOverflow = 1'b0;
        dec.aluOp         = ALU_ADD;
        dec.wbSource      = WB_ALU_OUT;
        dec.wbDest        = DST_RT;

        case (opcode)
            R_FORMAT: begin
                dec.wbDest = DST_RD;
                case (funct)
                    ADD: begin
                        dec.instrClass    = CLS_ALU_REG;
                        dec.trapsOverflow = 1'b1;
                    end
                    SUB: begin
                        dec.instrClass    = CLS_ALU_REG;
                        dec.aluOp         = ALU_SUB;
                        dec.trapsOverflow = 1'b1;
                    end
                    AND: begin
                        dec.instrClass = CLS_ALU_REG;
                        dec.aluOp      = ALU_AND;
                    end
                    SLT: begin
                        dec.instrClass = CLS_ALU_REG;
                        dec.aluOp      = ALU_CMP;
                        dec.wbSource   = WB_LESS_THAN;
                    end
                    default: dec.instrClass = CLS_ILLEGAL; // unknown funct traps too
                endcase
            end
            ADDI: begin
                dec.instrClass    = CLS_ALU_IMM;
                dec.trapsOverflow = 1'b1;
            end
            ADDIU: dec.instrClass = CLS_ALU_IMM; // no trap
            SLTI: begin
                dec.instrClass = CLS_ALU_IMM;
                dec.aluOp      = ALU_CMP;
                dec.wbSource   = WB_LESS_THAN;
            end
            LUI: begin
                dec.instrClass = CLS_ALU_IMM;
                dec.wbSource   = WB_UPPER_IMM;
            end
            BEQ: begin
                dec.instrClass = CLS_BRANCH;
                dec.branchCond = BR_EQ;
            end
            BNE: begin
                dec.instrClass = CLS_BRANCH;
                dec.branchCond = BR_NE;
            end
            BLE: begin
                dec.instrClass = CLS_BRANCH;
                dec.branchCond = BR_LE;
            end
            BGT: begin
                dec.instrClass = CLS_BRANCH;
                dec.branchCond = BR_GT;
            end
            LW:  dec.instrClass = CLS_LOAD;
            SW:  dec.instrClass = CLS_STORE;
            J:   dec.instrClass = CLS_JUMP;
            JAL: dec.instrClass = CLS_JUMP_LINK;
            default: dec.instrClass = CLS_ILLEGAL;
        endcase
    end

endmodule

//--- hw/isaPkg.sv
`include "mips_cfg.svh"

package isaPkg;

    typedef enum logic [`OPCODE_W-1:0] {
        R_FORMAT = 6'h00,
        J        = 6'h02,
        JAL      = 6'h03,
        BEQ      = 6'h04,
        BNE      = 6'h05,
        BLE      = 6'h06,
        BGT      = 6'h07,
        ADDI     = 6'h08,
        ADDIU    = 6'h09,
        SLTI     = 6'h0a,
        LUI      = 6'h0f,
        LW       = 6'h23,
        SW       = 6'h2b
    } opcode_t;

    // only meaningful under R_FORMAT
    typedef enum logic [`FUNCT_W-1:0] {
        ADD = 6'h20,
        SUB = 6'h22,
        AND = 6'h24,
        SLT = 6'h2a
    } funct_t;

    typedef enum logic [2:0] {
        CLS_ALU_REG,
        CLS_ALU_IMM,
        CLS_LOAD,
        CLS_STORE,
        CLS_BRANCH,
        CLS_JUMP,
        CLS_JUMP_LINK,
        CLS_ILLEGAL
    } instrClass_t;

    typedef enum logic [1:0] {
        BR_EQ, // beq
        BR_NE, // bne
        BR_GT, // bgt
        BR_LE  // ble, taken when not greater
    } branchCond_t;

endpackage

//--- hw/mainSequencer.sv
module mainSequencer import isaPkg::*, ctrlPkg::*; (
    input  logic       clk,
    input  logic       reset,
    decodeIf.sequencer dec,
    input  logic       overflow,
    input  logic       equal,
    input  logic       greater,
    input  logic       timerDone,
    output logic       timerStart,
    output ctrlState_t state
);

    ctrlState_t nextState;
    logic       takeBranch;

    always_comb begin
        case (dec.branchCond)
            BR_EQ:   takeBranch = equal;
            BR_NE:   takeBranch = !equal;
            BR_GT:   takeBranch = greater;
            default: takeBranch = !greater;
        endcase
    end

    always_comb begin
        nextState  = FETCH_ADDR;
        timerStart = 1'b0;

        case (state)
            FETCH_ADDR:    nextState = FETCH_PC;
            FETCH_PC:      nextState = FETCH_IR;
            FETCH_IR:      nextState = DECODE_TARGET;
            DECODE_TARGET: nextState = DECODE_REGS;
            DECODE_REGS: begin
                case (dec.instrClass)
                    CLS_ALU_REG:   nextState = EXEC_ALU_R;
                    CLS_ALU_IMM:   nextState = EXEC_ALU_I;
                    CLS_LOAD,
                    CLS_STORE:     nextState = EXEC_MEM;
                    CLS_BRANCH:    nextState = EXEC_BRANCH;
                    CLS_JUMP:      nextState = JUMP;
                    CLS_JUMP_LINK: nextState = EXEC_JAL;
                    default:       nextState = OPC_EPC;
                endcase
            end

            EXEC_ALU_R,
            EXEC_ALU_I: begin
                if (dec.trapsOverflow && overflow) begin
                    nextState = OVF_EPC;
                end else begin
                    nextState = ALU_WB;
                end
            end
            ALU_WB: nextState = FINISH;

            EXEC_MEM: begin
                nextState  = MEM_WAIT;
                timerStart = 1'b1;
            end
            MEM_WAIT: begin
                if (!timerDone) begin
                    nextState = MEM_WAIT;
                end else if (dec.instrClass == CLS_LOAD) begin
                    nextState = LOAD_WB;
                end else begin
                    nextState = STORE_WRITE;
                end
            end
            LOAD_WB,
            STORE_WRITE: nextState = FINISH;

            EXEC_BRANCH: nextState = takeBranch ? BRANCH_TAKE : FINISH;
            BRANCH_TAKE: nextState = FINISH;

            JUMP:     nextState = FINISH;
            EXEC_JAL: nextState = JAL_LINK;
            JAL_LINK: nextState = JUMP;   // link first, then jump

            OPC_EPC: nextState = OPC_VECTOR;
            OVF_EPC: nextState = OVF_VECTOR;
            OPC_VECTOR,
            OVF_VECTOR: begin
                nextState  = EXC_WAIT;
                timerStart = 1'b1;
            end
            EXC_WAIT: nextState = timerDone ? EXC_LOAD : EXC_WAIT;
            EXC_LOAD: nextState = FINISH;

            FINISH:  nextState = FETCH_ADDR;
            default: nextState = FETCH_ADDR;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= FETCH_ADDR;
        end else begin
            state <= nextState;
        end
    end

endmodule

//--- hw/mips_cfg.svh
`ifndef MIPS_CFG_SVH
`define MIPS_CFG_SVH

// instruction fields seen by the control unit
`define OPCODE_W 6
`define FUNCT_W 6

// fixed memory latency, address to valid read data
`define MEM_WAIT_CYCLES 2

// must hold MEM_WAIT_CYCLES
`define WAIT_CNT_W 2

`endif

//--- hw/waitTimer.sv
`include "mips_cfg.svh"

module waitTimer (
    input  logic clk,
    input  logic reset,
    input  logic start,
    output logic done
);

    logic [`WAIT_CNT_W-1:0] count;

    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
        end else if (start) begin
            count <= `WAIT_CNT_W'(`MEM_WAIT_CYCLES);
        end else if (count != '0) begin
            count <= count - 1'b1;
        end
    end

    // high while the last wait cycle runs
    assign done = (count == `WAIT_CNT_W'(1));

endmodule

//--- run.sh
#!/bin/sh
# builds and runs the control unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary -f build.f --top-module ctrlTopTb -Mdir obj_dir -o ctrlTopSim
if [ $? -ne 0 ]; then
    echo "run.sh: verilator compile failed"
    exit 1
fi

./obj_dir/ctrlTopSim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "run.sh: simulation exited with status $status"
    exit 1
fi

if grep -q "test failed" sim.log; then
    echo "run.sh: failure reported in sim.log"
    exit 1
fi
exit 0
